/* hdl/cart_pkg.sv */
`default_nettype none

package cart_pkg;

   // one sampled CPU bus cycle
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        cs;
      logic        wr;
      logic        rd;
      logic        mreq;
      logic        iorq;
      logic        m1;
   } cpu_bus_t;

   // request toward the shared ROM/RAM memory
   typedef struct packed {
      logic [24:0] addr;
      logic [7:0]  wdata;
      logic        we;
   } mem_req_t;

   typedef struct packed {
      logic [7:0] rdata;
   } mem_resp_t;

   // magic pair value that unlocks the work RAM
   localparam logic [15:0] MAGIC_KEY = 16'h694D;

   // offsets inside the 16 KB cartridge window
   localparam logic [13:0] OFS_MAGIC_LO  = 14'h1FFE;
   localparam logic [13:0] OFS_MAGIC_HI  = 14'h1FFF;
   localparam logic [13:0] OFS_OPLL_ADDR = 14'h3FF4;
   localparam logic [13:0] OFS_OPLL_DATA = 14'h3FF5;
   localparam logic [13:0] OFS_ENABLE    = 14'h3FF6;
   localparam logic [13:0] OFS_BANK      = 14'h3FF7;

   // I/O ports 7C and 7D share this prefix
   localparam logic [6:0] OPLL_IO_PORT = 7'h3E;

endpackage

`default_nettype wire

/* hdl/fm_pac_cart.sv */
`timescale 1ns/1ps
`default_nettype none

module fm_pac_cart #(
   parameter logic [24:0] ROM_BASE  = 25'h0000000,
   parameter logic [24:0] SRAM_BASE = 25'h1000000,
   parameter int          NUM_FM_CH = 9
) (
   input  wire                      clk,
   input  wire                      reset,
   input  wire cart_pkg::cpu_bus_t  bus,
   output wire [7:0]                d_to_cpu,
   output wire                      cart_oe,
   output wire                      cpu_wait,
   input  wire cart_pkg::mem_req_t  host_req,
   input  wire                      host_req_valid,
   output wire                      host_req_ready,
   output cart_pkg::mem_resp_t      host_resp,
   output wire                      host_resp_valid,
   output wire [31:0]               awaddr,
   output wire                      awvalid,
   input  wire                      awready,
   output wire [31:0]               wdata,
   output wire [3:0]                wstrb,
   output wire                      wvalid,
   input  wire                      wready,
   input  wire [1:0]                bresp,
   input  wire                      bvalid,
   output wire                      bready,
   output wire [31:0]               araddr,
   output wire                      arvalid,
   input  wire                      arready,
   input  wire [31:0]               rdata,
   input  wire [1:0]                rresp,
   input  wire                      rvalid,
   output wire                      rready,
   output wire [NUM_FM_CH-1:0]      key_on
);

   cart_pkg::mem_req_t  cpu_req;
   cart_pkg::mem_resp_t cpu_resp;
   wire                 cpu_req_valid;
   wire                 cpu_req_ready;
   wire                 cpu_resp_valid;
   wire                 fm_wr;
   wire                 fm_a0;

   fm_pac_mapper #(
      .ROM_BASE  (ROM_BASE),
      .SRAM_BASE (SRAM_BASE)
   ) u_mapper (
      .clk            (clk),
      .reset          (reset),
      .bus            (bus),
      .d_to_cpu       (d_to_cpu),
      .cart_oe        (cart_oe),
      .cpu_wait       (cpu_wait),
      .mem_req        (cpu_req),
      .mem_req_valid  (cpu_req_valid),
      .mem_req_ready  (cpu_req_ready),
      .mem_resp       (cpu_resp),
      .mem_resp_valid (cpu_resp_valid),
      .fm_wr          (fm_wr),
      .fm_a0          (fm_a0)
   );

   fm_reg_file #(
      .NUM_FM_CH (NUM_FM_CH)
   ) u_fm_regs (
      .clk       (clk),
      .reset     (reset),
      .bus       (bus),
      .mem_fm_wr (fm_wr),
      .mem_fm_a0 (fm_a0),
      .key_on    (key_on)
   );

   // mapper on port a, host backup port on b
   mem_arbiter u_arbiter (
      .clk          (clk),
      .reset        (reset),
      .a_req        (cpu_req),
      .a_req_valid  (cpu_req_valid),
      .a_req_ready  (cpu_req_ready),
      .a_resp       (cpu_resp),
      .a_resp_valid (cpu_resp_valid),
      .b_req        (host_req),
      .b_req_valid  (host_req_valid),
      .b_req_ready  (host_req_ready),
      .b_resp       (host_resp),
      .b_resp_valid (host_resp_valid),
      .awaddr       (awaddr),
      .awvalid      (awvalid),
      .awready      (awready),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .wvalid       (wvalid),
      .wready       (wready),
      .bresp        (bresp),
      .bvalid       (bvalid),
      .bready       (bready),
      .araddr       (araddr),
      .arvalid      (arvalid),
      .arready      (arready),
      .rdata        (rdata),
      .rresp        (rresp),
      .rvalid       (rvalid),
      .rready       (rready)
   );

endmodule

`default_nettype wire

/* hdl/fm_pac_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module fm_pac_mapper #(
   parameter logic [24:0] ROM_BASE  = 25'h0000000,
   parameter logic [24:0] SRAM_BASE = 25'h1000000
) (
   input  wire                 clk,
   input  wire                 reset,
   input  wire cart_pkg::cpu_bus_t  bus,
   output logic [7:0]          d_to_cpu,
   output logic                cart_oe,
   output logic                cpu_wait,
   output cart_pkg::mem_req_t  mem_req,
   output logic                mem_req_valid,
   input  wire                 mem_req_ready,
   input  wire cart_pkg::mem_resp_t mem_resp,
   input  wire                 mem_resp_valid,
   output logic                fm_wr,
   output logic                fm_a0
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_RESP,
      ST_HOLD
   } state_t;

   state_t      state;
   logic [7:0]  enable;
   logic [1:0]  bank;
   logic [7:0]  magic_lo;
   logic [7:0]  magic_hi;
   logic [7:0]  rdata_q;
   logic        rd_q;
   logic [13:0] ofs;
   logic        sram_en;
   logic        ram_sel;
   logic        mem_cycle;
   logic        magic_ofs;
   logic        reg_rd_hit;
   logic        reg_wr_hit;
   logic        reg_wr;
   logic        mem_rd;
   logic        mem_wr;
   logic        data_ok;
   logic [7:0]  reg_data;

   assign ofs       = bus.addr[13:0];
   assign sram_en   = {magic_hi, magic_lo} == cart_pkg::MAGIC_KEY;
   assign ram_sel   = sram_en & ~ofs[13];
   assign mem_cycle = bus.cs & bus.mreq;
   assign magic_ofs = (ofs == cart_pkg::OFS_MAGIC_LO) | (ofs == cart_pkg::OFS_MAGIC_HI);

   // register readback, magic bytes only visible once unlocked
   always_comb begin
      reg_rd_hit = 1'b1;
      reg_data   = 8'hFF;
      case (ofs)
         cart_pkg::OFS_ENABLE: reg_data = enable;
         cart_pkg::OFS_BANK:   reg_data = {6'b000000, bank};
         cart_pkg::OFS_MAGIC_LO: begin
            reg_data   = magic_lo;
            reg_rd_hit = sram_en;
         end
         cart_pkg::OFS_MAGIC_HI: begin
            reg_data   = magic_hi;
            reg_rd_hit = sram_en;
         end
         default: reg_rd_hit = 1'b0;
      endcase
   end

   assign reg_wr_hit = (ofs == cart_pkg::OFS_OPLL_ADDR) | (ofs == cart_pkg::OFS_OPLL_DATA) |
                       (ofs == cart_pkg::OFS_ENABLE) | (ofs == cart_pkg::OFS_BANK) |
                       (magic_ofs & ~enable[4]);
   assign reg_wr = mem_cycle & bus.wr & reg_wr_hit;
   assign mem_rd = mem_cycle & bus.rd & ~reg_rd_hit;
   // ROM writes are dropped here
   assign mem_wr = mem_cycle & bus.wr & ~reg_wr_hit & ram_sel;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= ST_IDLE;
         enable   <= 8'h00;
         bank     <= 2'b00;
         magic_lo <= 8'h00;
         magic_hi <= 8'h00;
         rd_q     <= 1'b0;
         fm_wr    <= 1'b0;
         fm_a0    <= 1'b0;
      end else begin
         fm_wr <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (mem_rd | mem_wr) begin
                  state <= ST_REQ;
                  rd_q  <= mem_rd;
               end else if (reg_wr) begin
                  state <= ST_HOLD;
                  rd_q  <= 1'b0;
                  case (ofs)
                     cart_pkg::OFS_MAGIC_LO: magic_lo <= bus.wdata;
                     cart_pkg::OFS_MAGIC_HI: magic_hi <= bus.wdata;
                     cart_pkg::OFS_ENABLE: begin
                        enable <= bus.wdata & 8'h11;
                        // old bit 4 decides, relocks the RAM
                        if (enable[4]) begin
                           magic_lo <= 8'h00;
                           magic_hi <= 8'h00;
                        end
                     end
                     cart_pkg::OFS_BANK: bank <= bus.wdata[1:0];
                     default: begin
                        fm_wr <= 1'b1;
                        fm_a0 <= ofs[0];
                     end
                  endcase
               end
            end
            ST_REQ: begin
               if (mem_req_ready) begin
                  state <= ST_RESP;
               end
            end
            ST_RESP: begin
               if (mem_resp_valid) begin
                  state <= ST_HOLD;
               end
            end
            default: begin
               // wait for the CPU to end its cycle
               if (!(mem_cycle & (bus.rd | bus.wr))) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // request payload follows the bus while idle, frozen afterwards
   always_ff @(posedge clk) begin
      if (state == ST_IDLE) begin
         mem_req.addr  <= ram_sel ? SRAM_BASE + 25'(ofs[12:0]) : ROM_BASE + 25'({bank, ofs});
         mem_req.wdata <= bus.wdata;
         mem_req.we    <= mem_wr;
      end
      if (state == ST_RESP && mem_resp_valid) begin
         rdata_q <= mem_resp.rdata;
      end
   end

   assign mem_req_valid = state == ST_REQ;
   assign cpu_wait      = (state == ST_REQ) | ((state == ST_RESP) & ~mem_resp_valid);

   // response byte bypassed in its arrival cycle
   assign data_ok  = rd_q & (((state == ST_RESP) & mem_resp_valid) | (state == ST_HOLD));
   assign cart_oe  = mem_cycle & bus.rd & (reg_rd_hit | data_ok);
   assign d_to_cpu = reg_rd_hit ? reg_data : ((state == ST_RESP) ? mem_resp.rdata : rdata_q);

   a_req_stable: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

`default_nettype wire

/* hdl/fm_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module fm_reg_file #(
   parameter int NUM_FM_CH = 9
) (
   input  wire                     clk,
   input  wire                     reset,
   input  wire cart_pkg::cpu_bus_t bus,
   input  wire                     mem_fm_wr,
   input  wire                     mem_fm_a0,
   output logic [NUM_FM_CH-1:0]    key_on
);

   // key-on flags live in bit 4 of registers 20 and up
   localparam logic [5:0] KEY_REG = 6'h20;

   logic       io_sel;
   logic       io_wr_q;
   logic       io_a0_q;
   logic [7:0] din_q;
   logic       wr;
   logic       a0;
   logic [5:0] idx;
   logic [7:0] regs [64];

   // I/O write to ports 7C/7D, opcode fetches excluded
   assign io_sel = bus.iorq & bus.wr & ~bus.m1 & (bus.addr[7:1] == cart_pkg::OPLL_IO_PORT);

   // delay the I/O strobe to line up with the mapper strobe
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         io_wr_q <= 1'b0;
         io_a0_q <= 1'b0;
      end else begin
         io_wr_q <= io_sel;
         io_a0_q <= bus.addr[0];
      end
   end

   always_ff @(posedge clk) begin
      din_q <= bus.wdata;
   end

   assign wr = io_wr_q | mem_fm_wr;
   assign a0 = io_wr_q ? io_a0_q : mem_fm_a0;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         idx <= 6'd0;
         for (int i = 0; i < 64; i++) begin
            regs[i] <= 8'h00;
         end
      end else if (wr) begin
         if (!a0) begin
            idx <= din_q[5:0];
         end else begin
            regs[idx] <= din_q;
         end
      end
   end

   for (genvar ch = 0; ch < NUM_FM_CH; ch++) begin : g_key
      assign key_on[ch] = regs[KEY_REG + 6'(ch)][4];
   end

   a_no_strobe_clash: assert property (@(posedge clk) disable iff (reset)
      !(io_wr_q && mem_fm_wr));

endmodule

`default_nettype wire

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
   input  wire                      clk,
   input  wire                      reset,
   input  wire cart_pkg::mem_req_t  a_req,
   input  wire                      a_req_valid,
   output logic                     a_req_ready,
   output cart_pkg::mem_resp_t      a_resp,
   output logic                     a_resp_valid,
   input  wire cart_pkg::mem_req_t  b_req,
   input  wire                      b_req_valid,
   output logic                     b_req_ready,
   output cart_pkg::mem_resp_t      b_resp,
   output logic                     b_resp_valid,
   output logic [31:0]              awaddr,
   output logic                     awvalid,
   input  wire                      awready,
   output logic [31:0]              wdata,
   output logic [3:0]               wstrb,
   output logic                     wvalid,
   input  wire                      wready,
   input  wire [1:0]                bresp,
   input  wire                      bvalid,
   output logic                     bready,
   output logic [31:0]              araddr,
   output logic                     arvalid,
   input  wire                      arready,
   input  wire [31:0]               rdata,
   input  wire [1:0]                rresp,
   input  wire                      rvalid,
   output logic                     rready
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_WRITE
   } state_t;

   state_t              state;
   logic                sel_b;
   logic                grant_a;
   logic                grant_b;
   logic                resp_pulse;
   logic [1:0]          lane;
   cart_pkg::mem_req_t  next_req;
   cart_pkg::mem_req_t  req_q;
   cart_pkg::mem_resp_t resp_q;

   // sel_b also remembers who was served last
   assign grant_b  = b_req_valid & (~a_req_valid | ~sel_b);
   assign grant_a  = a_req_valid & ~grant_b;
   assign next_req = grant_b ? b_req : a_req;

   assign a_req_ready = (state == ST_IDLE) & grant_a;
   assign b_req_ready = (state == ST_IDLE) & grant_b;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state      <= ST_IDLE;
         sel_b      <= 1'b0;
         awvalid    <= 1'b0;
         wvalid     <= 1'b0;
         arvalid    <= 1'b0;
         resp_pulse <= 1'b0;
      end else begin
         resp_pulse <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (grant_a | grant_b) begin
                  sel_b <= grant_b;
                  if (next_req.we) begin
                     state   <= ST_WRITE;
                     awvalid <= 1'b1;
                     wvalid  <= 1'b1;
                  end else begin
                     state   <= ST_READ;
                     arvalid <= 1'b1;
                  end
               end
            end
            ST_READ: begin
               if (arready) begin
                  arvalid <= 1'b0;
               end
               if (rvalid) begin
                  state      <= ST_IDLE;
                  resp_pulse <= 1'b1;
               end
            end
            default: begin
               // AW and W may complete in either order
               if (awready) begin
                  awvalid <= 1'b0;
               end
               if (wready) begin
                  wvalid <= 1'b0;
               end
               if (bvalid) begin
                  state      <= ST_IDLE;
                  resp_pulse <= 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE) begin
         req_q <= next_req;
      end
      // error responses come back as FF
      if (state == ST_READ && rvalid) begin
         resp_q.rdata <= rresp[1] ? 8'hFF : rdata[8*lane +: 8];
      end
      if (state == ST_WRITE && bvalid) begin
         resp_q.rdata <= {8{bresp[1]}};
      end
   end

   // byte lane from the low address bits
   assign lane   = req_q.addr[1:0];
   assign awaddr = 32'(req_q.addr);
   assign araddr = 32'(req_q.addr);
   assign wdata  = {4{req_q.wdata}};
   assign wstrb  = 4'b0001 << lane;
   assign bready = state == ST_WRITE;
   assign rready = state == ST_READ;

   assign a_resp       = resp_q;
   assign b_resp       = resp_q;
   assign a_resp_valid = resp_pulse & ~sel_b;
   assign b_resp_valid = resp_pulse & sel_b;

   a_one_resp: assert property (@(posedge clk) disable iff (reset)
      $onehot0({a_resp_valid, b_resp_valid}));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --Wno-fatal \
   --top-module tb_fm_pac_cart -f src.f \
   --Mdir obj_dir -o tb_sim > build.log 2>&1 \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log \
   && { echo "simulation failed, see sim.log"; exit 1; } \
   || { echo "simulation passed"; exit 0; }

/* sim/axi_lite_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_mem_model (
   input  wire         clk,
   input  wire         reset,
   input  wire  [31:0] awaddr,
   input  wire         awvalid,
   output logic        awready,
   input  wire  [31:0] wdata,
   input  wire  [3:0]  wstrb,
   input  wire         wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  wire         bready,
   input  wire  [31:0] araddr,
   input  wire         arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  wire         rready
);

   logic [31:0] lfsr;
   logic [7:0]  bytes_q [logic [31:0]];
   logic [31:0] raddr_q;
   int          wst;
   int          rst;
   int          wcnt;
   int          rcnt;

   assign bresp = 2'b00;
   assign rresp = 2'b00;

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // 0 to 3 cycles, one LFSR step per bit
   function automatic int draw_delay();
      int d;
      d = 0;
      for (int i = 0; i < 2; i++) begin
         lfsr = lfsr_step(lfsr);
         d = (d << 1) | int'(lfsr[0]);
      end
      return d;
   endfunction

   // unwritten bytes follow the address
   function automatic logic [7:0] fetch_byte(input logic [31:0] a);
      if (bytes_q.exists(a)) begin
         return bytes_q[a];
      end
      return a[7:0] ^ a[15:8];
   endfunction

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         lfsr = 32'h55ab4a2d;
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rdata   <= 32'h0;
         wst     <= 0;
         rst     <= 0;
         wcnt    <= 0;
         rcnt    <= 0;
      end else begin
         // write channel
         case (wst)
            0: if (awvalid && wvalid) begin
               wcnt <= draw_delay();
               wst  <= 1;
            end
            1: if (wcnt == 0) begin
               awready <= 1'b1;
               wready  <= 1'b1;
               for (int i = 0; i < 4; i++) begin
                  if (wstrb[i]) begin
                     bytes_q[{awaddr[31:2], 2'(i)}] = wdata[8*i +: 8];
                  end
               end
               wst <= 2;
            end else begin
               wcnt <= wcnt - 1;
            end
            2: begin
               awready <= 1'b0;
               wready  <= 1'b0;
               wcnt    <= draw_delay();
               wst     <= 3;
            end
            3: if (wcnt == 0) begin
               bvalid <= 1'b1;
               wst    <= 4;
            end else begin
               wcnt <= wcnt - 1;
            end
            default: if (bready) begin
               bvalid <= 1'b0;
               wst    <= 0;
            end
         endcase
         // read channel
         case (rst)
            0: if (arvalid) begin
               rcnt <= draw_delay();
               rst  <= 1;
            end
            1: if (rcnt == 0) begin
               arready <= 1'b1;
               raddr_q <= {araddr[31:2], 2'b00};
               rst     <= 2;
            end else begin
               rcnt <= rcnt - 1;
            end
            2: begin
               arready <= 1'b0;
               rcnt    <= draw_delay();
               rst     <= 3;
            end
            3: if (rcnt == 0) begin
               rdata  <= {fetch_byte(raddr_q + 3), fetch_byte(raddr_q + 2),
                          fetch_byte(raddr_q + 1), fetch_byte(raddr_q)};
               rvalid <= 1'b1;
               rst    <= 4;
            end else begin
               rcnt <= rcnt - 1;
            end
            default: if (rready) begin
               rvalid <= 1'b0;
               rst    <= 0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* sim/tb_fm_pac_cart.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fm_pac_cart;

   localparam int K_MRD  = 0;
   localparam int K_MWR  = 1;
   localparam int K_IOWR = 2;
   localparam int K_HRD  = 3;
   localparam int K_HWR  = 4;
   localparam int K_OVL  = 5;

   localparam int C_NONE = 0;
   localparam int C_VAL  = 1;
   localparam int C_MEM  = 2;
   localparam int C_KEY  = 3;

   typedef struct {
      string       name;
      int          kind;
      logic [15:0] addr;
      logic [7:0]  data;
      int          chk;
      logic [24:0] exp;
      logic [24:0] haddr;
   } entry_t;

   logic                clk;
   logic                reset;
   cart_pkg::cpu_bus_t  bus;
   wire [7:0]           d_to_cpu;
   wire                 cart_oe;
   wire                 cpu_wait;
   cart_pkg::mem_req_t  host_req;
   logic                host_req_valid;
   wire                 host_req_ready;
   cart_pkg::mem_resp_t host_resp;
   wire                 host_resp_valid;
   wire [31:0]          awaddr;
   wire                 awvalid;
   wire                 awready;
   wire [31:0]          wdata;
   wire [3:0]           wstrb;
   wire                 wvalid;
   wire                 wready;
   wire [1:0]           bresp;
   wire                 bvalid;
   wire                 bready;
   wire [31:0]          araddr;
   wire                 arvalid;
   wire                 arready;
   wire [31:0]          rdata;
   wire [1:0]           rresp;
   wire                 rvalid;
   wire                 rready;
   wire [8:0]           key_on;

   entry_t              tests[$];
   logic [7:0]          shadow [logic [24:0]];
   int                  errors;
   int                  checks;
   int                  host_acc;
   logic                table_ready;

   fm_pac_cart #(
      .ROM_BASE  (25'h0000000),
      .SRAM_BASE (25'h1000000),
      .NUM_FM_CH (9)
   ) uut (
      .clk(clk), .reset(reset), .bus(bus),
      .d_to_cpu(d_to_cpu), .cart_oe(cart_oe), .cpu_wait(cpu_wait),
      .host_req(host_req), .host_req_valid(host_req_valid),
      .host_req_ready(host_req_ready), .host_resp(host_resp),
      .host_resp_valid(host_resp_valid),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .key_on(key_on)
   );

   axi_lite_mem_model u_mem (
      .clk(clk), .reset(reset),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
   );

   always #4 clk = ~clk;

   // counts accepted host requests
   always @(posedge clk) begin
      if (host_req_valid && host_req_ready) begin
         host_acc <= host_acc + 1;
      end
   end

   function automatic logic [7:0] predict(input logic [24:0] a);
      if (shadow.exists(a)) begin
         return shadow[a];
      end
      return a[7:0] ^ a[15:8];
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERROR %s expected %0h actual %0h", name, exp, act);
      end
   endtask

   task automatic add(input string name, input int kind, input logic [15:0] addr,
                      input logic [7:0] data, input int chk, input logic [24:0] exp,
                      input logic [24:0] haddr = 25'h0);
      entry_t e;
      e.name  = name;
      e.kind  = kind;
      e.addr  = addr;
      e.data  = data;
      e.chk   = chk;
      e.exp   = exp;
      e.haddr = haddr;
      tests.push_back(e);
   endtask

   // one memory cycle, held while the cartridge waits
   task automatic cpu_access(input logic [15:0] a, input logic we, input logic [7:0] d,
                             output logic [7:0] r, output logic oe);
      bus.addr  = a;
      bus.wdata = d;
      bus.cs    = 1'b1;
      bus.mreq  = 1'b1;
      bus.wr    = we;
      bus.rd    = ~we;
      @(negedge clk);
      while (cpu_wait) @(negedge clk);
      r   = d_to_cpu;
      oe  = cart_oe;
      bus = '0;
      @(negedge clk);
      @(negedge clk);
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] d);
      bus.addr  = {8'h00, port};
      bus.wdata = d;
      bus.iorq  = 1'b1;
      bus.wr    = 1'b1;
      bus.m1    = 1'b0;
      @(negedge clk);
      bus = '0;
      @(negedge clk);
      @(negedge clk);
   endtask

   task automatic host_xfer(input logic we, input logic [24:0] a, input logic [7:0] d,
                            output logic [7:0] r);
      int acc0;
      acc0 = host_acc;
      host_req.addr  = a;
      host_req.wdata = d;
      host_req.we    = we;
      host_req_valid = 1'b1;
      @(negedge clk);
      while (host_acc == acc0) @(negedge clk);
      host_req_valid = 1'b0;
      while (!host_resp_valid) @(negedge clk);
      r = host_resp.rdata;
      @(negedge clk);
   endtask

   task automatic build_table();
      // register readback
      add("enable_wr_ff", K_MWR, 16'h7FF6, 8'hFF, C_NONE, 0);
      add("enable_rd_11", K_MRD, 16'h7FF6, 8'h00, C_VAL, 25'h11);
      add("enable_wr_00", K_MWR, 16'h7FF6, 8'h00, C_NONE, 0);
      add("enable_rd_00", K_MRD, 16'h7FF6, 8'h00, C_VAL, 25'h00);
      add("bank_wr_06", K_MWR, 16'h7FF7, 8'h06, C_NONE, 0);
      add("bank_rd_02", K_MRD, 16'h7FF7, 8'h00, C_VAL, 25'h02);
      // ROM mapping over banks
      add("rom_b2", K_MRD, 16'h4123, 8'h00, C_MEM, 25'h0008123);
      add("bank_wr_0", K_MWR, 16'h7FF7, 8'h00, C_NONE, 0);
      add("rom_b0", K_MRD, 16'h4ABC, 8'h00, C_MEM, 25'h0000ABC);
      add("bank_wr_3", K_MWR, 16'h7FF7, 8'h03, C_NONE, 0);
      add("rom_b3", K_MRD, 16'h7F00, 8'h00, C_MEM, 25'h000FF00);
      add("bank_wr_1", K_MWR, 16'h7FF7, 8'h01, C_NONE, 0);
      add("rom_b1", K_MRD, 16'h5555, 8'h00, C_MEM, 25'h0005555);
      // locked RAM window
      add("locked_wr", K_MWR, 16'h4010, 8'h5A, C_NONE, 0);
      add("locked_rd", K_MRD, 16'h4010, 8'h00, C_MEM, 25'h0004010);
      add("locked_host", K_HRD, 16'h0, 8'h00, C_MEM, 25'h1000010);
      // unlock
      add("magic_lo_wr", K_MWR, 16'h5FFE, 8'h4D, C_NONE, 0);
      add("magic_hi_wr", K_MWR, 16'h5FFF, 8'h69, C_NONE, 0);
      add("magic_lo_rd", K_MRD, 16'h5FFE, 8'h00, C_VAL, 25'h4D);
      add("magic_hi_rd", K_MRD, 16'h5FFF, 8'h00, C_VAL, 25'h69);
      add("ram_wr_010", K_MWR, 16'h4010, 8'h5A, C_MEM, 25'h1000010);
      add("ram_rd_010", K_MRD, 16'h4010, 8'h00, C_MEM, 25'h1000010);
      add("ram_wr_1ffd", K_MWR, 16'h5FFD, 8'hC3, C_MEM, 25'h1001FFD);
      add("ram_rd_1ffd", K_MRD, 16'h5FFD, 8'h00, C_MEM, 25'h1001FFD);
      add("rom_unlocked", K_MRD, 16'h6234, 8'h00, C_MEM, 25'h0006234);
      // shared memory with the host
      add("host_rd_cpu", K_HRD, 16'h0, 8'h00, C_MEM, 25'h1000010);
      add("host_wr_123", K_HWR, 16'h0, 8'h77, C_NONE, 25'h1000123);
      add("cpu_rd_host", K_MRD, 16'h4123, 8'h00, C_MEM, 25'h1000123);
      add("host_wr_200", K_HWR, 16'h0, 8'h99, C_NONE, 25'h1000200);
      add("overlap_1", K_OVL, 16'h4010, 8'h00, C_MEM, 25'h1000010, 25'h1000200);
      add("overlap_2", K_OVL, 16'h6234, 8'h00, C_MEM, 25'h0006234, 25'h1001FFD);
      // enable bit 4 blocks magic writes, they land in RAM instead
      add("enable_wr_10", K_MWR, 16'h7FF6, 8'h10, C_NONE, 0);
      add("magic_blocked", K_MWR, 16'h5FFE, 8'h00, C_MEM, 25'h1001FFE);
      add("magic_kept", K_MRD, 16'h5FFE, 8'h00, C_VAL, 25'h4D);
      add("enable_relock", K_MWR, 16'h7FF6, 8'h00, C_NONE, 0);
      add("relocked_rd", K_MRD, 16'h4010, 8'h00, C_MEM, 25'h0004010);
      add("magic_gone", K_MRD, 16'h5FFE, 8'h00, C_MEM, 25'h0005FFE);
      add("host_rd_1ffe", K_HRD, 16'h0, 8'h00, C_MEM, 25'h1001FFE);
      // FM key-on over both paths
      add("fm_mem_a_21", K_MWR, 16'h7FF4, 8'h21, C_NONE, 0);
      add("fm_mem_d_10", K_MWR, 16'h7FF5, 8'h10, C_KEY, 25'h002);
      add("fm_io_a_24", K_IOWR, 16'h7C, 8'h24, C_NONE, 0);
      add("fm_io_d_1f", K_IOWR, 16'h7D, 8'h1F, C_KEY, 25'h012);
      add("fm_io_a_21", K_IOWR, 16'h7C, 8'h21, C_NONE, 0);
      add("fm_io_d_00", K_IOWR, 16'h7D, 8'h00, C_KEY, 25'h010);
      add("fm_mem_a_28", K_MWR, 16'h7FF4, 8'h28, C_NONE, 0);
      add("fm_mem_d_30", K_MWR, 16'h7FF5, 8'h30, C_KEY, 25'h110);
      add("fm_io_a_10", K_IOWR, 16'h7C, 8'h10, C_NONE, 0);
      add("fm_io_d_10", K_IOWR, 16'h7D, 8'h10, C_KEY, 25'h110);
   endtask

   task automatic apply(input entry_t e);
      logic [7:0] r;
      logic [7:0] hr;
      logic       oe;
      case (e.kind)
         K_MRD: begin
            cpu_access(e.addr, 1'b0, 8'h00, r, oe);
            check_val({e.name, "_oe"}, 1, oe);
            check_val(e.name, (e.chk == C_MEM) ? predict(e.exp) : e.exp[7:0], r);
         end
         K_MWR: begin
            cpu_access(e.addr, 1'b1, e.data, r, oe);
            if (e.chk == C_MEM) begin
               shadow[e.exp] = e.data;
            end
            if (e.chk == C_KEY) begin
               check_val(e.name, e.exp[8:0], key_on);
            end
         end
         K_IOWR: begin
            io_write(e.addr[7:0], e.data);
            if (e.chk == C_KEY) begin
               check_val(e.name, e.exp[8:0], key_on);
            end
         end
         K_HRD: begin
            host_xfer(1'b0, e.exp, 8'h00, hr);
            check_val(e.name, predict(e.exp), hr);
         end
         K_HWR: begin
            host_xfer(1'b1, e.exp, e.data, hr);
            shadow[e.exp] = e.data;
         end
         default: begin
            fork
               cpu_access(e.addr, 1'b0, 8'h00, r, oe);
               host_xfer(1'b0, e.haddr, 8'h00, hr);
            join
            check_val({e.name, "_cpu"}, predict(e.exp), r);
            check_val({e.name, "_host"}, predict(e.haddr), hr);
         end
      endcase
   endtask

   // watchdog sized from the table length
   initial begin
      wait (table_ready);
      repeat (tests.size() * 40) @(posedge clk);
      $display("watchdog expired before the test table completed");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      clk            = 1'b0;
      reset          = 1'b1;
      bus            = '0;
      host_req       = '0;
      host_req_valid = 1'b0;
      host_acc       = 0;
      errors         = 0;
      checks         = 0;
      table_ready    = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_val("reset_key_on", 0, key_on);
      check_val("reset_wait", 0, cpu_wait);
      foreach (tests[i]) begin
         apply(tests[i]);
      end
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
hdl/cart_pkg.sv
hdl/fm_pac_mapper.sv
hdl/fm_reg_file.sv
hdl/mem_arbiter.sv
hdl/fm_pac_cart.sv
sim/axi_lite_mem_model.sv
sim/tb_fm_pac_cart.sv
